/* common/eeprom_pkg.sv */
package eeprom_pkg;

    localparam int QUARTER_CYCLES = 2; // scl period is four of these
    localparam int QCNT_W = (QUARTER_CYCLES > 1) ? $clog2(QUARTER_CYCLES) : 1;
    localparam int ADDR_W = 11;
    localparam logic [3:0] DEV_CODE = 4'b1010;

    // operations handed to the frame engine
    typedef enum logic [1:0] {
        FRM_START,
        FRM_STOP,
        FRM_WRITE,
        FRM_READ
    } frame_op_e;

    typedef struct packed {
        frame_op_e  op;
        logic [7:0] tx_byte;
        logic       master_ack; // level driven in the ack slot of a read
    } frame_cmd_t;

    typedef struct packed {
        logic [7:0] rx_byte;
        logic       ack_seen;   // device pulled sda low after a write byte
    } frame_rsp_t;

    // single bus symbols
    typedef enum logic [1:0] {
        BIT_START,
        BIT_STOP,
        BIT_SEND,
        BIT_SAMPLE
    } bit_op_e;

    typedef struct packed {
        bit_op_e op;
        logic    value;
    } bit_cmd_t;

    // host request as latched by the sequencer
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [7:0]        wdata;
        logic              is_read;
    } eeprom_req_t;

endpackage

/* i2c/i2c_bit_engine.sv */
`timescale 1ns/100ps

module i2c_bit_engine (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 bit_go,
    input  eeprom_pkg::bit_cmd_t cmd,
    input  logic                 sda_in,
    output logic                 bit_done,
    output logic                 rx_bit,
    output logic                 scl,
    output logic                 sda_oe
);
    import eeprom_pkg::*;

    logic              active;
    logic [1:0]        quarter; // 0,1 scl low  2,3 scl high
    logic [QCNT_W-1:0] qcnt;
    logic              qlast;
    bit_cmd_t          cur;

    assign qlast    = (qcnt == QCNT_W'(QUARTER_CYCLES - 1));
    assign bit_done = active && (quarter == 2'd3) && qlast;

    always_ff @(posedge CLK)
    begin
        if (bit_go)
            cur <= cmd;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active  <= 1'b0;
            quarter <= 2'd0;
            qcnt    <= '0;
            scl     <= 1'b1; // bus idle
            sda_oe  <= 1'b0;
            rx_bit  <= 1'b1;
        end
        else if (bit_go)
        begin
            active  <= 1'b1;
            quarter <= 2'd0;
            qcnt    <= '0;
            scl     <= 1'b0;
        end
        else if (active)
        begin
            if (qlast)
            begin
                quarter <= quarter + 2'd1;
                qcnt    <= '0;
            end
            else
                qcnt <= qcnt + 1'b1;

            if (bit_done)
                active <= 1'b0;

            // data set up one cycle after scl falls
            if (quarter == 2'd0 && qcnt == '0)
            begin
                case (cur.op)
                    BIT_STOP:   sda_oe <= 1'b1;
                    BIT_SEND:   sda_oe <= !cur.value;
                    default:    sda_oe <= 1'b0; // start and sample release the line
                endcase
            end

            if (quarter == 2'd1 && qlast)
                scl <= 1'b1;

            // middle of the high phase
            if (quarter == 2'd2 && qlast)
            begin
                rx_bit <= sda_in;
                if (cur.op == BIT_START)
                    sda_oe <= 1'b1;
                else if (cur.op == BIT_STOP)
                    sda_oe <= 1'b0;
            end
        end
    end

    sda_stable_while_scl_high: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && (sda_oe != $past(sda_oe)))
        |-> (cur.op inside {BIT_START, BIT_STOP}));

    no_go_mid_symbol: assert property (@(posedge CLK) disable iff (RESET)
        bit_go |-> (!active || bit_done));

endmodule

/* i2c/i2c_frame_engine.sv */
`timescale 1ns/100ps

module i2c_frame_engine (
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   frame_go,
    input  eeprom_pkg::frame_cmd_t cmd,
    output logic                   frame_done,
    output eeprom_pkg::frame_rsp_t rsp,
    output logic                   bit_go,
    output eeprom_pkg::bit_cmd_t   bit_cmd,
    input  logic                   bit_done,
    input  logic                   rx_bit
);
    import eeprom_pkg::*;

    logic       busy;
    logic       first;      // first symbol leaves the cycle after frame_go
    frame_op_e  op;
    logic       master_ack;
    logic [7:0] shreg;
    logic [3:0] cnt;        // symbols issued so far
    logic       is_byte;
    logic [3:0] last_cnt;

    assign is_byte    = (op == FRM_WRITE) || (op == FRM_READ);
    assign last_cnt   = is_byte ? 4'd9 : 4'd1;
    assign frame_done = busy && bit_done && (cnt == last_cnt);

    // next symbol chained onto bit_done keeps the bus bits back to back
    assign bit_go = busy && (first || (bit_done && (cnt != last_cnt)));

    assign rsp.rx_byte  = shreg;
    assign rsp.ack_seen = (op == FRM_WRITE) && !rx_bit;

    // cnt already points at the symbol about to be issued
    always_comb
    begin
        bit_cmd.op    = BIT_SAMPLE;
        bit_cmd.value = 1'b1;
        case (op)
            FRM_START:  bit_cmd.op = BIT_START;
            FRM_STOP:   bit_cmd.op = BIT_STOP;
            FRM_WRITE:
                if (cnt != 4'd8)
                begin
                    bit_cmd.op    = BIT_SEND;
                    bit_cmd.value = shreg[7]; // msb first
                end
            FRM_READ:
                if (cnt == 4'd8)
                begin
                    bit_cmd.op    = BIT_SEND;
                    bit_cmd.value = master_ack;
                end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy  <= 1'b0;
            first <= 1'b0;
            cnt   <= 4'd0;
        end
        else
        begin
            first <= frame_go;
            if (frame_go)
            begin
                busy <= 1'b1;
                cnt  <= 4'd0;
            end
            else
            begin
                if (bit_go)
                    cnt <= cnt + 4'd1;
                if (frame_done)
                    busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (frame_go)
        begin
            op         <= cmd.op;
            master_ack <= cmd.master_ack;
            shreg      <= cmd.tx_byte;
        end
        else if (bit_go && op == FRM_WRITE)
            shreg <= {shreg[6:0], 1'b0};
        else if (busy && bit_done && op == FRM_READ && cnt <= 4'd8)
            shreg <= {shreg[6:0], rx_bit}; // data bits only, not the ack slot
    end

    no_go_mid_frame: assert property (@(posedge CLK) disable iff (RESET)
        frame_go |-> !busy);

endmodule

/* source/eeprom_sequencer.sv */
`timescale 1ns/100ps

module eeprom_sequencer (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                    wdata,
    output logic                          busy,
    output logic                          ack,
    output logic                          nack,
    output logic [7:0]                    rdata,
    output logic                          frame_go,
    output eeprom_pkg::frame_cmd_t        frame_cmd,
    input  logic                          frame_done,
    input  eeprom_pkg::frame_rsp_t        frame_rsp
);
    import eeprom_pkg::*;

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL_W,
        S_ADDR,
        S_DATA,
        S_RESTART,
        S_CTRL_R,
        S_READ,
        S_STOP,
        S_ACK
    } state_e;

    state_e      state;
    eeprom_req_t req;
    logic        accept;
    logic        nack_pend;
    logic [7:0]  rx_hold;
    logic [7:0]  ctrl_w;
    logic [7:0]  ctrl_r;

    function automatic frame_cmd_t mk_cmd(frame_op_e op, logic [7:0] data, logic ma);
        frame_cmd_t c;
        c.op         = op;
        c.tx_byte    = data;
        c.master_ack = ma;
        return c;
    endfunction

    assign accept = !busy && (wr || rd);
    assign ctrl_w = {DEV_CODE, req.addr[ADDR_W-1:8], 1'b0};
    assign ctrl_r = {DEV_CODE, req.addr[ADDR_W-1:8], 1'b1};

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            req.addr    <= addr;
            req.wdata   <= wdata;
            req.is_read <= !wr; // write wins
        end
        if (state == S_READ && frame_done)
            rx_hold <= frame_rsp.rx_byte;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= S_IDLE;
            busy      <= 1'b0;
            ack       <= 1'b0;
            nack      <= 1'b0;
            rdata     <= 8'h00;
            frame_go  <= 1'b0;
            frame_cmd <= '0;
            nack_pend <= 1'b0;
        end
        else
        begin
            frame_go <= 1'b0;
            ack      <= 1'b0;
            case (state)
                S_IDLE:
                    if (accept)
                    begin
                        busy      <= 1'b1;
                        nack_pend <= 1'b0;
                        frame_go  <= 1'b1;
                        frame_cmd <= mk_cmd(FRM_START, 8'h00, 1'b1);
                        state     <= S_START;
                    end
                S_START:
                    if (frame_done)
                    begin
                        frame_go  <= 1'b1;
                        frame_cmd <= mk_cmd(FRM_WRITE, ctrl_w, 1'b1);
                        state     <= S_CTRL_W;
                    end
                S_CTRL_W, S_ADDR, S_DATA, S_CTRL_R:
                    if (frame_done)
                    begin
                        frame_go <= 1'b1;
                        if (!frame_rsp.ack_seen)
                        begin
                            nack_pend <= 1'b1; // device silent, straight to stop
                            frame_cmd <= mk_cmd(FRM_STOP, 8'h00, 1'b1);
                            state     <= S_STOP;
                        end
                        else
                        begin
                            case (state)
                                S_CTRL_W:
                                begin
                                    frame_cmd <= mk_cmd(FRM_WRITE, req.addr[7:0], 1'b1);
                                    state     <= S_ADDR;
                                end
                                S_ADDR:
                                    if (req.is_read)
                                    begin
                                        frame_cmd <= mk_cmd(FRM_START, 8'h00, 1'b1);
                                        state     <= S_RESTART;
                                    end
                                    else
                                    begin
                                        frame_cmd <= mk_cmd(FRM_WRITE, req.wdata, 1'b1);
                                        state     <= S_DATA;
                                    end
                                S_CTRL_R:
                                begin
                                    // single byte read ends with no ack
                                    frame_cmd <= mk_cmd(FRM_READ, 8'h00, 1'b1);
                                    state     <= S_READ;
                                end
                                default:
                                begin
                                    frame_cmd <= mk_cmd(FRM_STOP, 8'h00, 1'b1);
                                    state     <= S_STOP;
                                end
                            endcase
                        end
                    end
                S_RESTART:
                    if (frame_done)
                    begin
                        frame_go  <= 1'b1;
                        frame_cmd <= mk_cmd(FRM_WRITE, ctrl_r, 1'b1);
                        state     <= S_CTRL_R;
                    end
                S_READ:
                    if (frame_done)
                    begin
                        frame_go  <= 1'b1;
                        frame_cmd <= mk_cmd(FRM_STOP, 8'h00, 1'b1);
                        state     <= S_STOP;
                    end
                S_STOP:
                    if (frame_done)
                    begin
                        ack  <= 1'b1;
                        nack <= nack_pend;
                        if (req.is_read && !nack_pend)
                            rdata <= rx_hold; // old data kept on nack
                        state <= S_ACK;
                    end
                S_ACK:
                begin
                    busy  <= 1'b0;
                    state <= S_IDLE;
                end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    ack_single_pulse: assert property (@(posedge CLK) disable iff (RESET)
        ack |=> !ack);

    ack_inside_busy: assert property (@(posedge CLK) disable iff (RESET)
        ack |-> busy);

endmodule

/* source/eeprom_ctrl.sv */
`timescale 1ns/100ps

module eeprom_ctrl (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                    wdata,
    input  logic                          sda_in,
    output logic                          busy,
    output logic                          ack,
    output logic                          nack,
    output logic [7:0]                    rdata,
    output logic                          scl,
    output logic                          sda_oe
);
    import eeprom_pkg::*;

    logic       frame_go;
    frame_cmd_t frame_cmd;
    logic       frame_done;
    frame_rsp_t frame_rsp;
    logic       bit_go;
    bit_cmd_t   bit_cmd;
    logic       bit_done;
    logic       rx_bit;

    eeprom_sequencer seq_i (
        .CLK        (CLK),
        .RESET      (RESET),
        .wr         (wr),
        .rd         (rd),
        .addr       (addr),
        .wdata      (wdata),
        .busy       (busy),
        .ack        (ack),
        .nack       (nack),
        .rdata      (rdata),
        .frame_go   (frame_go),
        .frame_cmd  (frame_cmd),
        .frame_done (frame_done),
        .frame_rsp  (frame_rsp)
    );

    i2c_frame_engine frame_i (
        .CLK        (CLK),
        .RESET      (RESET),
        .frame_go   (frame_go),
        .cmd        (frame_cmd),
        .frame_done (frame_done),
        .rsp        (frame_rsp),
        .bit_go     (bit_go),
        .bit_cmd    (bit_cmd),
        .bit_done   (bit_done),
        .rx_bit     (rx_bit)
    );

    // only block touching the pins
    i2c_bit_engine bit_i (
        .CLK      (CLK),
        .RESET    (RESET),
        .bit_go   (bit_go),
        .cmd      (bit_cmd),
        .sda_in   (sda_in),
        .bit_done (bit_done),
        .rx_bit   (rx_bit),
        .scl      (scl),
        .sda_oe   (sda_oe)
    );

endmodule

/* bench/eeprom_model.sv */
`timescale 1ns/100ps

module eeprom_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    input  logic ack_enable,
    output logic sda_pull
);
    import eeprom_pkg::*;

    typedef enum logic [2:0] {
        M_IDLE,
        M_DEV,
        M_ADDR,
        M_WDATA,
        M_READ
    } mstate_e;

    logic [7:0]        mem [0:(1 << ADDR_W) - 1];
    mstate_e           state;
    mstate_e           next_state;
    logic [3:0]        bitcnt;     // scl rises seen in this byte
    logic [7:0]        shreg;
    logic [7:0]        rbyte;
    logic [2:0]        blk;
    logic [ADDR_W-1:0] ptr;
    logic [7:0]        wbuf;
    logic              pending;
    logic              scl_q;
    logic              sda_q;

    // contents depend on every address bit
    function automatic logic [7:0] initial_byte(input logic [ADDR_W-1:0] a);
        return a[7:0] ^ {a[10:8], a[10:8], 2'b10};
    endfunction

    initial
    begin
        for (int i = 0; i < (1 << ADDR_W); i++)
            mem[i] = initial_byte(ADDR_W'(i));
    end

    // bus pins oversampled on CLK, edges found from the previous sample
    always @(posedge CLK)
    begin
        scl_q <= scl;
        sda_q <= sda;
        if (RESET)
        begin
            state    <= M_IDLE;
            bitcnt   <= 4'd0;
            pending  <= 1'b0;
            sda_pull <= 1'b0;
        end
        else if (scl_q && scl && sda_q && !sda) // start or repeated start
        begin
            state    <= M_DEV;
            bitcnt   <= 4'd0;
            sda_pull <= 1'b0;
        end
        else if (scl_q && scl && !sda_q && sda) // stop commits the write
        begin
            if (pending)
                mem[ptr] <= wbuf;
            pending  <= 1'b0;
            state    <= M_IDLE;
            sda_pull <= 1'b0;
        end
        else if (state != M_IDLE)
        begin
            if (!scl_q && scl)
            begin
                shreg  <= {shreg[6:0], sda};
                bitcnt <= bitcnt + 4'd1;
            end
            else if (scl_q && !scl)
            begin
                if (bitcnt == 4'd8)
                begin
                    sda_pull   <= 1'b0; // also frees the line for the master ack
                    next_state <= M_IDLE;
                    case (state)
                        M_DEV:
                            if (shreg[7:4] == DEV_CODE && ack_enable)
                            begin
                                blk        <= shreg[3:1];
                                next_state <= shreg[0] ? M_READ : M_ADDR;
                                sda_pull   <= 1'b1;
                            end
                        M_ADDR:
                            if (ack_enable)
                            begin
                                ptr        <= {blk, shreg};
                                next_state <= M_WDATA;
                                sda_pull   <= 1'b1;
                            end
                        M_WDATA:
                            if (ack_enable)
                            begin
                                wbuf     <= shreg;
                                pending  <= 1'b1;
                                sda_pull <= 1'b1;
                            end
                        default:
                            next_state <= M_IDLE;
                    endcase
                end
                else if (bitcnt == 4'd9)
                begin
                    bitcnt   <= 4'd0;
                    state    <= next_state;
                    rbyte    <= mem[ptr];
                    sda_pull <= (next_state == M_READ) && !mem[ptr][7]; // msb first
                end
                else if (state == M_READ)
                    sda_pull <= !rbyte[3'd7 - bitcnt[2:0]];
            end
        end
    end

endmodule

/* bench/tb_eeprom_ctrl.sv */
`timescale 1ns/100ps

module tb_eeprom_ctrl;
    import eeprom_pkg::*;

    // a read frame is 39 bus bits of 8 cycles plus frame gaps
    localparam int TXN_TOTAL   = 51;
    localparam int TXN_CYCLES  = 400;
    localparam int CYCLE_LIMIT = TXN_TOTAL * TXN_CYCLES;

    logic              CLK;
    logic              RESET;
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        wdata;
    logic              busy;
    logic              ack;
    logic              nack;
    logic [7:0]        rdata;
    logic              scl;
    logic              sda_oe;
    logic              mem_pull;
    logic              sda_line;
    logic              ack_enable;

    logic [31:0] lfsr_state;
    logic [7:0]  shadow [0:(1 << ADDR_W) - 1];
    string       test_name;
    int          err_count;
    int          errs_at_start;
    int          tests_passed;
    int          tests_failed;
    int          cycle_count;

    assign sda_line = !(sda_oe || mem_pull); // open drain, either side pulls low

    eeprom_ctrl dut_i (
        .CLK    (CLK),
        .RESET  (RESET),
        .wr     (wr),
        .rd     (rd),
        .addr   (addr),
        .wdata  (wdata),
        .sda_in (sda_line),
        .busy   (busy),
        .ack    (ack),
        .nack   (nack),
        .rdata  (rdata),
        .scl    (scl),
        .sda_oe (sda_oe)
    );

    eeprom_model mem_i (
        .CLK        (CLK),
        .RESET      (RESET),
        .scl        (scl),
        .sda        (sda_line),
        .ack_enable (ack_enable),
        .sda_pull   (mem_pull)
    );

    initial
    begin
        CLK = 1'b0;
        forever #4 CLK = !CLK;
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT)
        begin
            @(posedge CLK);
            cycle_count++;
        end
        $display("Timeout: no result after %0d cycles in test %s", CYCLE_LIMIT, test_name);
        $display("Simulation FAILED");
        $finish;
    end

    // same fill rule as the device model
    function automatic logic [7:0] initial_byte(input logic [ADDR_W-1:0] a);
        return a[7:0] ^ {a[10:8], a[10:8], 2'b10};
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // x^32+x^22+x^2+x+1
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic compare_byte(input string what, input logic [7:0] expected,
                                input logic [7:0] actual);
        if (actual !== expected)
        begin
            err_count++;
            $display("Mismatch in %s, %s: expected %02h, actual %02h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic compare_flag(input string what, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            err_count++;
            $display("Mismatch in %s, %s: expected %b, actual %b",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic begin_test(input string name);
        test_name     = name;
        errs_at_start = err_count;
    endtask

    task automatic end_test();
        if (err_count == errs_at_start)
        begin
            tests_passed++;
            $display("test %s: ok", test_name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: %0d check(s) failed", test_name, err_count - errs_at_start);
        end
    endtask

    task automatic send_strobe(input logic is_read, input logic [ADDR_W-1:0] a,
                               input logic [7:0] d);
        @(negedge CLK);
        wr    = !is_read;
        rd    = is_read;
        addr  = a;
        wdata = d;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
    endtask

    // bounded by the cycle watchdog
    task automatic wait_for_ack(output logic got_nack, output logic [7:0] got_data);
        while (ack !== 1'b1)
            @(negedge CLK);
        got_nack = nack;
        got_data = rdata;
    endtask

    task automatic run_txn(input logic is_read, input logic [ADDR_W-1:0] a, input logic [7:0] d,
                           output logic got_nack, output logic [7:0] got_data);
        send_strobe(is_read, a, d);
        wait_for_ack(got_nack, got_data);
    endtask

    task automatic write_byte(input logic [ADDR_W-1:0] a, input logic [7:0] d);
        logic       got_nack;
        logic [7:0] got_data;
        run_txn(1'b0, a, d, got_nack, got_data);
        compare_flag($sformatf("write nack @%03h", a), 1'b0, got_nack);
        shadow[a] = d;
    endtask

    task automatic read_check(input logic [ADDR_W-1:0] a);
        logic       got_nack;
        logic [7:0] got_data;
        run_txn(1'b1, a, 8'h00, got_nack, got_data);
        compare_flag($sformatf("read nack @%03h", a), 1'b0, got_nack);
        compare_byte($sformatf("read data @%03h", a), shadow[a], got_data);
    endtask

    task automatic check_reset_state();
        begin_test("reset_state");
        repeat (4)
        begin
            @(negedge CLK);
            compare_flag("busy", 1'b0, busy);
            compare_flag("ack", 1'b0, ack);
            compare_flag("scl", 1'b1, scl);
            compare_flag("sda_oe", 1'b0, sda_oe);
            compare_flag("nack", 1'b0, nack);
            compare_byte("rdata", 8'h00, rdata);
        end
        end_test();
    endtask

    task automatic write_then_read();
        logic [ADDR_W-1:0] a;
        begin_test("write_then_read");
        repeat (2)
        begin
            a = ADDR_W'(random_bits(ADDR_W));
            write_byte(a, 8'(random_bits(8)));
            read_check(a);
        end
        end_test();
    endtask

    // same low byte in every block, so only the control byte tells them apart
    task automatic upper_address_bits();
        begin_test("upper_address_bits");
        for (int b = 0; b < 8; b++)
            write_byte({3'(b), 8'h5c}, {3'(b), 5'(random_bits(5))});
        for (int b = 0; b < 8; b++)
            read_check({3'(b), 8'h5c});
        end_test();
    endtask

    task automatic ignore_busy_strobe();
        logic [ADDR_W-1:0] a_first;
        logic [ADDR_W-1:0] a_second;
        logic [7:0]        d_first;
        logic              got_nack;
        logic [7:0]        got_data;
        begin_test("ignore_busy_strobe");
        a_first  = 11'h2a5;
        a_second = 11'h4b6;
        d_first  = 8'(random_bits(8));
        send_strobe(1'b0, a_first, d_first);
        repeat (20) @(negedge CLK);
        compare_flag("busy during write", 1'b1, busy);
        send_strobe(1'b0, a_second, ~shadow[a_second]);
        wait_for_ack(got_nack, got_data);
        compare_flag("write nack", 1'b0, got_nack);
        shadow[a_first] = d_first;
        repeat (4)
        begin
            @(negedge CLK);
            compare_flag("busy after ack", 1'b0, busy);
        end
        read_check(a_first);
        read_check(a_second);
        end_test();
    endtask

    task automatic missing_acknowledge();
        logic [ADDR_W-1:0] a;
        logic [7:0]        prev;
        logic              got_nack;
        logic [7:0]        got_data;
        begin_test("missing_acknowledge");
        a = 11'h613;
        read_check(a); // leaves a known value in rdata
        prev = shadow[a];
        @(negedge CLK);
        ack_enable = 1'b0;
        run_txn(1'b0, a, ~prev, got_nack, got_data);
        compare_flag("write nack", 1'b1, got_nack);
        run_txn(1'b1, a, 8'h00, got_nack, got_data);
        compare_flag("read nack", 1'b1, got_nack);
        compare_byte("rdata held", prev, got_data);
        @(negedge CLK);
        ack_enable = 1'b1;
        read_check(a);
        end_test();
    endtask

    task automatic random_traffic();
        logic              is_read;
        logic [2:0]        hi3;
        logic [2:0]        lo3;
        logic [ADDR_W-1:0] a;
        logic [7:0]        d;
        begin_test("random_traffic");
        for (int i = 0; i < 24; i++)
        begin
            is_read = 1'(random_bits(1));
            hi3     = 3'(random_bits(3));
            lo3     = 3'(random_bits(3));
            a       = {hi3, 5'b01101, lo3}; // small window so reads hit earlier writes
            d       = 8'(random_bits(8));
            if (is_read)
                read_check(a);
            else
                write_byte(a, d);
        end
        end_test();
    endtask

    initial
    begin
        RESET        = 1'b1;
        wr           = 1'b0;
        rd           = 1'b0;
        addr         = '0;
        wdata        = '0;
        ack_enable   = 1'b1;
        lfsr_state   = 32'hdeb4_cbf7;
        test_name    = "reset";
        err_count    = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int i = 0; i < (1 << ADDR_W); i++)
            shadow[i] = initial_byte(ADDR_W'(i));
        repeat (5) @(negedge CLK);
        RESET = 1'b0;

        check_reset_state();
        write_then_read();
        upper_address_bits();
        ignore_busy_strobe();
        missing_acknowledge();
        random_traffic();

        $display("tests passed: %0d, tests failed: %0d, failed checks: %0d",
                 tests_passed, tests_failed, err_count);
        if (err_count == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

/* compile.f */
common/eeprom_pkg.sv
i2c/i2c_bit_engine.sv
i2c/i2c_frame_engine.sv
source/eeprom_sequencer.sv
source/eeprom_ctrl.sv
bench/eeprom_model.sv
bench/tb_eeprom_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_eeprom_ctrl -f compile.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || echo "build or simulation error"
cat sim.log 2>/dev/null
grep -qs "Simulation PASSED" sim.log && echo "result: pass" && exit 0 \
    || { echo "result: fail"; exit 1; }
